/* design/isa_pkg.sv */
// Instruction formats, opcodes, instruction union and the latency class helper
package isa_pkg;

	// Opcodes above op_mul_hi are unassigned
	// They run on the ALU and produce zero
	typedef enum logic [3:0]
	{
		op_add    = 4'h0,
		op_sub    = 4'h1,
		op_and    = 4'h2,
		op_or     = 4'h3,
		op_xor    = 4'h4,
		op_mul_lo = 4'h5,
		op_mul_hi = 4'h6
	} opcode_t;

	// The top bit of every instruction word selects how the rest is read
	typedef enum logic
	{
		format_reg = 1'b0,
		format_imm = 1'b1
	} format_t;

	// Register format, where operand b comes straight from the request
	typedef struct packed
	{
		format_t     format;
		opcode_t     opcode;
		logic [26:0] unused;
	} reg_format_t;

	// Immediate format, where the sign-extended low half word replaces operand b
	typedef struct packed
	{
		format_t     format;
		opcode_t     opcode;
		logic [10:0] unused;
		logic [15:0] immediate;
	} imm_format_t;

	// Both views share the format bit and the opcode position
	typedef union packed
	{
		reg_format_t reg_fmt;
		imm_format_t imm_fmt;
	} instruction_t;

	// Only the two multiply opcodes take the long pipeline
	function automatic logic is_multi_cycle(opcode_t opcode);
		return opcode inside {op_mul_lo, op_mul_hi};
	endfunction

endpackage

/* design/pipe_pkg.sv */
// Thread index, issue request, execute operation and result structs
package pipe_pkg;
	import isa_pkg::*;

	// Index of one of the hardware threads
	typedef logic [1:0] thread_id_t;

	// What a thread offers to the issue stage while its pending level is up
	// The thread holds this steady until it sees its grant
	typedef struct packed
	{
		instruction_t instruction;
		logic [31:0]  operand_a;
		logic [31:0]  operand_b;
	} issue_request_t;

	// The issued instruction after format decode
	// Operand b already holds either the request value or the extended immediate
	typedef struct packed
	{
		logic        valid;
		thread_id_t  thread;
		opcode_t     opcode;
		logic [31:0] operand_a;
		logic [31:0] operand_b;
	} execute_op_t;

	// A result tagged with the thread that issued it
	typedef struct packed
	{
		thread_id_t  thread;
		logic [31:0] value;
	} result_t;

	// Output of either execute pipeline on its way to the writeback mux
	typedef struct packed
	{
		logic    valid;
		result_t result;
	} stage_result_t;

endpackage

/* design/latency_decoder.sv */
// Latency class decoder for one instruction word
module latency_decoder
	import isa_pkg::*;
	(
	input  instruction_t instruction,
	output logic         single_cycle_result,
	output logic         multi_cycle_result);

	opcode_t opcode;

	// Both formats keep the opcode in the same bits
	// The register view therefore reads it for either format
	assign opcode = instruction.reg_fmt.opcode;

	// Multiplies go down the long pipeline
	// Everything else, including unassigned opcodes, finishes in the ALU
	always_comb
	begin
		multi_cycle_result = is_multi_cycle(opcode);
		single_cycle_result = !multi_cycle_result;
	end

endmodule

/* design/execute_hazard_detect.sv */
// Writeback collision tracking between the ALU and multiplier pipelines
module execute_hazard_detect
	import pipe_pkg::*;
	#(
	parameter int num_threads = 4,
	parameter int multiply_stages = 4)
	(
	input  logic                                 clk,
	input  logic                                 reset,
	input  issue_request_t [num_threads - 1:0]   thread_request,
	input  logic [num_threads - 1:0]             issued_oh,
	output logic [num_threads - 1:0]             execute_hazard);

	logic [num_threads - 1:0]     single_cycle;
	logic [num_threads - 1:0]     multi_cycle;
	logic                         issued_is_multi_cycle;
	logic [multiply_stages - 2:0] writeback_allocate;

	// Each thread's waiting instruction gets its own decoder, since any of
	// them may be the one picked this cycle
	for (genvar i = 0; i < num_threads; i++)
	begin : thread_decode
		latency_decoder decoder(
			.instruction(thread_request[i].instruction),
			.single_cycle_result(single_cycle[i]),
			.multi_cycle_result(multi_cycle[i]));
	end

	assign issued_is_multi_cycle = |(issued_oh & multi_cycle);

	// Bit k is set when a multiply issued k+1 cycles ago
	// Counting the issue cycle itself as position 0, the top bit is
	// position multiply_stages-1, the cycle when issuing a single-cycle op
	// would land it on the writeback mux together with that multiply
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			writeback_allocate <= '0;
		else
			writeback_allocate <= (writeback_allocate << 1)
				| (multiply_stages - 1)'(issued_is_multi_cycle);
	end

	// Multiplies never collide with each other, so only ALU ops are held off
	assign execute_hazard = {num_threads{writeback_allocate[multiply_stages - 2]}}
		& single_cycle;

	// The shift register only tracks one issue per cycle
	issue_one_hot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(issued_oh));

endmodule

/* design/thread_issue.sv */
// Round-robin thread arbiter and issue register with operand b resolution
module thread_issue
	import isa_pkg::*, pipe_pkg::*;
	#(
	parameter int num_threads = 4)
	(
	input  logic                               clk,
	input  logic                               reset,
	input  logic [num_threads - 1:0]           thread_pending,
	input  issue_request_t [num_threads - 1:0] thread_request,
	input  logic [num_threads - 1:0]           execute_hazard,
	output logic [num_threads - 1:0]           issued_oh,
	output execute_op_t                        issue_op);

	logic [num_threads - 1:0] eligible;
	thread_id_t               last_grant;
	thread_id_t               grant_id;
	logic                     grant_found;
	issue_request_t           winner;
	logic [31:0]              resolved_b;

	// A hazarded thread sits out this cycle but keeps its place in the rotation
	assign eligible = thread_pending & ~execute_hazard;

	// Search starts one past the last winner so every thread gets a turn
	always_comb
	begin
		int idx;

		issued_oh = '0;
		grant_id = last_grant;
		grant_found = 1'b0;
		for (int i = 1; i <= num_threads; i++)
		begin
			idx = (int'(last_grant) + i) % num_threads;
			if (!grant_found && eligible[idx])
			begin
				grant_found = 1'b1;
				grant_id = thread_id_t'(idx);
				issued_oh[idx] = 1'b1;
			end
		end
	end

	assign winner = thread_request[grant_id];

	// Immediate format swaps operand b for the sign-extended immediate
	always_comb
	begin
		if (winner.instruction.imm_fmt.format == format_imm)
			resolved_b = {{16{winner.instruction.imm_fmt.immediate[15]}},
				winner.instruction.imm_fmt.immediate};
		else
			resolved_b = winner.operand_b;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			issue_op <= '0;
			last_grant <= '0;
		end
		else
		begin
			issue_op.valid <= grant_found;
			issue_op.thread <= grant_id;
			issue_op.opcode <= winner.instruction.reg_fmt.opcode;
			issue_op.operand_a <= winner.operand_a;
			issue_op.operand_b <= resolved_b;

			// The pointer only moves when somebody actually wins
			if (grant_found)
				last_grant <= grant_id;
		end
	end

	// A thread that is passed over keeps its pending level and its request
	// unchanged until it is granted
	for (genvar i = 0; i < num_threads; i++)
	begin : request_hold
		request_held: assert property (@(posedge clk) disable iff (reset)
			(thread_pending[i] && !issued_oh[i])
				|=> (thread_pending[i] && $stable(thread_request[i])));
	end

endmodule

/* design/single_cycle_alu.sv */
// One-stage ALU for add, subtract and bitwise logic operations
module single_cycle_alu
	import isa_pkg::*, pipe_pkg::*;
	(
	input  logic          clk,
	input  logic          reset,
	input  execute_op_t   issue_op,
	output stage_result_t alu_result);

	logic [31:0] alu_value;
	logic        alu_accept;

	// Multiplies belong to the other pipeline and are dropped here
	assign alu_accept = issue_op.valid && !is_multi_cycle(issue_op.opcode);

	// Add and subtract wrap at 32 bits with no flags
	always_comb
	begin
		case (issue_op.opcode)
			op_add:
				alu_value = issue_op.operand_a + issue_op.operand_b;
			op_sub:
				alu_value = issue_op.operand_a - issue_op.operand_b;
			op_and:
				alu_value = issue_op.operand_a & issue_op.operand_b;
			op_or:
				alu_value = issue_op.operand_a | issue_op.operand_b;
			op_xor:
				alu_value = issue_op.operand_a ^ issue_op.operand_b;
			default:
				alu_value = '0;
		endcase
	end

	// The single register stage, one cycle after issue_op
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			alu_result <= '0;
		else
		begin
			alu_result.valid <= alu_accept;
			alu_result.result.thread <= issue_op.thread;
			alu_result.result.value <= alu_value;
		end
	end

endmodule

/* design/multi_cycle_multiplier.sv */
// Pipelined unsigned 32x32 multiplier returning the low or high product word
module multi_cycle_multiplier
	import isa_pkg::*, pipe_pkg::*;
	#(
	parameter int multiply_stages = 4)
	(
	input  logic          clk,
	input  logic          reset,
	input  execute_op_t   issue_op,
	output stage_result_t mul_result);

	// Everything that rides along with the product down the chain
	typedef struct packed
	{
		thread_id_t  thread;
		logic        high;
		logic [63:0] product;
	} mul_stage_t;

	logic                                       mul_accept;
	logic [multiply_stages - 2:0]               stage_valid;
	mul_stage_t [multiply_stages - 2:0]         stage_data;
	mul_stage_t                                 last_stage;

	assign mul_accept = issue_op.valid && is_multi_cycle(issue_op.opcode);

	// The product is formed up front and carried through the chain
	// so that synthesis can retime the multiplier across the stages
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage_valid <= '0;
		else
		begin
			stage_valid[0] <= mul_accept;
			for (int k = 1; k < multiply_stages - 1; k++)
				stage_valid[k] <= stage_valid[k - 1];
		end
	end

	always_ff @(posedge clk)
	begin
		stage_data[0].thread <= issue_op.thread;
		stage_data[0].high <= issue_op.opcode == op_mul_hi;
		stage_data[0].product <= 64'(issue_op.operand_a) * 64'(issue_op.operand_b);
		for (int k = 1; k < multiply_stages - 1; k++)
			stage_data[k] <= stage_data[k - 1];
	end

	assign last_stage = stage_data[multiply_stages - 2];

	// Final stage picks the requested word, multiply_stages cycles after issue_op
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			mul_result <= '0;
		else
		begin
			mul_result.valid <= stage_valid[multiply_stages - 2];
			mul_result.result.thread <= last_stage.thread;
			mul_result.result.value <= last_stage.high ? last_stage.product[63:32]
				: last_stage.product[31:0];
		end
	end

endmodule

/* design/writeback_merge.sv */
// Writeback mux merging the ALU and multiplier results onto one registered port
module writeback_merge
	import pipe_pkg::*;
	(
	input  logic          clk,
	input  logic          reset,
	input  stage_result_t alu_result,
	input  stage_result_t mul_result,
	output logic          result_valid,
	output result_t       result);

	// The strobe follows either pipeline's valid one cycle later
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= alu_result.valid || mul_result.valid;
	end

	// With no collision possible the select only needs one of the valids
	always_ff @(posedge clk)
	begin
		if (mul_result.valid)
			result <= mul_result.result;
		else
			result <= alu_result.result;
	end

	// Issue-side hazard tracking is what keeps the two pipelines apart here
	// A hit means a result was silently dropped at the mux
	no_writeback_collision: assert property (@(posedge clk) disable iff (reset)
		!(alu_result.valid && mul_result.valid));

endmodule

/* design/execute_pipeline.sv */
// Issue and execute slice top level with hazard detection, both pipelines and writeback
module execute_pipeline
	import pipe_pkg::*;
	#(
	parameter int num_threads = 4,
	parameter int multiply_stages = 4)
	(
	input  logic                               clk,
	input  logic                               reset,
	input  logic [num_threads - 1:0]           thread_pending,
	input  issue_request_t [num_threads - 1:0] thread_request,
	output logic [num_threads - 1:0]           issued_oh,
	output logic                               result_valid,
	output result_t                            result);

	logic [num_threads - 1:0] execute_hazard;
	execute_op_t              issue_op;
	stage_result_t            alu_result;
	stage_result_t            mul_result;

	// Looks at the waiting requests and the multiplies already in flight
	execute_hazard_detect #(
		.num_threads(num_threads),
		.multiply_stages(multiply_stages)) hazard_detect(
		.clk(clk),
		.reset(reset),
		.thread_request(thread_request),
		.issued_oh(issued_oh),
		.execute_hazard(execute_hazard));

	thread_issue #(
		.num_threads(num_threads)) issue(
		.clk(clk),
		.reset(reset),
		.thread_pending(thread_pending),
		.thread_request(thread_request),
		.execute_hazard(execute_hazard),
		.issued_oh(issued_oh),
		.issue_op(issue_op));

	// Both pipelines see every issue_op and each keeps only its own class
	single_cycle_alu alu(
		.clk(clk),
		.reset(reset),
		.issue_op(issue_op),
		.alu_result(alu_result));

	multi_cycle_multiplier #(
		.multiply_stages(multiply_stages)) multiplier(
		.clk(clk),
		.reset(reset),
		.issue_op(issue_op),
		.mul_result(mul_result));

	writeback_merge writeback(
		.clk(clk),
		.reset(reset),
		.alu_result(alu_result),
		.mul_result(mul_result),
		.result_valid(result_valid),
		.result(result));

endmodule

/* tb/execute_pipeline_tb.sv */
// Testbench for the execute pipeline with file-driven thread stimulus, issue model and result checks
module execute_pipeline_tb
	import isa_pkg::*, pipe_pkg::*;
	();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_threads = 4;
	localparam int multiply_stages = 4;
	localparam int max_cases = 64;
	localparam int words_per_case = 5;
	localparam int single_latency = 3;
	localparam int multi_latency = multiply_stages + 2;

	logic                               clk;
	logic                               reset;
	logic [num_threads - 1:0]           thread_pending;
	issue_request_t [num_threads - 1:0] thread_request;
	logic [num_threads - 1:0]           issued_oh;
	logic                               result_valid;
	result_t                            result;

	// Five words per case: thread, instruction, operand a, operand b, expected value
	logic [31:0] case_words [words_per_case * max_cases];
	int          case_count;
	int          case_gap [max_cases];
	int          thread_cases [num_threads][$];
	int          cur_case [num_threads];
	int          timeout_limit;

	// Owned by the negedge monitor
	logic [num_threads - 1:0]     outstanding = '0;
	int                           due_cycle [num_threads];
	logic [31:0]                  expected_value [num_threads];
	int                           results_seen = 0;
	int                           cycle_count = 0;
	thread_id_t                   last_grant_model = '0;
	logic [multiply_stages - 2:0] multi_history = '0;

	execute_pipeline #(
		.num_threads(num_threads),
		.multiply_stages(multiply_stages)) UUT(
		.clk(clk),
		.reset(reset),
		.thread_pending(thread_pending),
		.thread_request(thread_request),
		.issued_oh(issued_oh),
		.result_valid(result_valid),
		.result(result));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	task automatic fail_run(string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic compare_value(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("error at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic compare_thread(string name, thread_id_t actual, thread_id_t expected);
		if (actual !== expected)
			fail_run($sformatf("error at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	task automatic compare_issue(string name, logic [num_threads - 1:0] actual,
		logic [num_threads - 1:0] expected);
		if (actual !== expected)
			fail_run($sformatf("error at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
	endtask

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		logic feedback;

		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// Round-robin pick that starts one past the previous winner
	function automatic logic [num_threads - 1:0] expected_grant(
		logic [num_threads - 1:0] eligible, thread_id_t last);
		logic [num_threads - 1:0] grant;
		int idx;

		grant = '0;
		for (int i = 1; i <= num_threads; i++)
		begin
			idx = (int'(last) + i) % num_threads;
			if (grant == '0 && eligible[idx])
				grant[idx] = 1'b1;
		end
		return grant;
	endfunction

	// Fills the per-thread queues and draws an idle gap for every case
	task automatic load_cases();
		logic [31:0] lfsr_state;
		int gap;

		// A thread word above the last thread marks the end of the cases
		for (int i = 0; i < words_per_case * max_cases; i++)
			case_words[i] = '1;
		$readmemh("tb/execute_cases.txt", case_words);
		lfsr_state = 32'h80dd;
		case_count = 0;
		while (case_count < max_cases
			&& case_words[case_count * words_per_case] < num_threads)
		begin
			// Two LFSR bits give zero to three idle cycles
			gap = 0;
			for (int b = 0; b < 2; b++)
			begin
				lfsr_state = lfsr_step(lfsr_state);
				gap = gap * 2 + int'(lfsr_state[0]);
			end
			case_gap[case_count] = gap;
			thread_cases[int'(case_words[case_count * words_per_case])].push_back(case_count);
			case_count++;
		end
		if (case_count == 0)
			fail_run("the cases file held no cases");
	endtask

	// One instruction in flight per thread, the next one waits for the result
	task automatic run_thread(int t);
		int idx;

		while (thread_cases[t].size() > 0)
		begin
			idx = thread_cases[t].pop_front();
			repeat (case_gap[idx])
				@(posedge clk);
			@(posedge clk);
			#1;
			cur_case[t] = idx;
			thread_request[t] = {case_words[idx * words_per_case + 1],
				case_words[idx * words_per_case + 2],
				case_words[idx * words_per_case + 3]};
			thread_pending[t] = 1'b1;
			wait (outstanding[t]);
			@(posedge clk);
			#1;
			thread_pending[t] = 1'b0;
			wait (!outstanding[t]);
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > timeout_limit)
			fail_run($sformatf("timeout: results never arrived within %0d cycles",
				timeout_limit));
	end

	// Everything is sampled mid-cycle, where the DUT outputs have settled
	always @(negedge clk)
	begin
		int matched;
		logic hazard_now;
		logic [num_threads - 1:0] single_mask;
		logic [num_threads - 1:0] grant;
		logic issued_multi;

		if (!reset)
		begin
			// A result belongs to the thread whose latency ends in this cycle
			if (result_valid)
			begin
				matched = -1;
				for (int k = 0; k < num_threads; k++)
					if (outstanding[k] && due_cycle[k] == cycle_count)
						matched = k;
				if (matched < 0)
					fail_run("a result arrived when no issued instruction was due");
				compare_thread("result.thread", result.thread, thread_id_t'(matched));
				compare_value("result.value", result.value, expected_value[matched]);
				outstanding[matched] = 1'b0;
				results_seen++;
			end
			for (int k = 0; k < num_threads; k++)
				if (outstanding[k] && due_cycle[k] <= cycle_count)
					fail_run($sformatf("no result arrived for thread %0d when it was due", k));

			// A multiply issued multiply_stages-1 cycles ago blocks single-cycle requests
			hazard_now = multi_history[multiply_stages - 2];
			for (int k = 0; k < num_threads; k++)
				single_mask[k] = !(thread_request[k].instruction.reg_fmt.opcode == op_mul_lo
					|| thread_request[k].instruction.reg_fmt.opcode == op_mul_hi);
			grant = expected_grant(thread_pending & ~({num_threads{hazard_now}} & single_mask),
				last_grant_model);
			compare_issue("issued_oh", issued_oh, grant);

			issued_multi = 1'b0;
			for (int k = 0; k < num_threads; k++)
			begin
				if (grant[k])
				begin
					issued_multi = !single_mask[k];
					outstanding[k] = 1'b1;
					due_cycle[k] = cycle_count + (issued_multi ? multi_latency : single_latency);
					expected_value[k] = case_words[cur_case[k] * words_per_case + 4];
					last_grant_model = thread_id_t'(k);
				end
			end

			// Age every tracked multiply by one cycle and record this cycle's issue
			for (int k = multiply_stages - 2; k > 0; k--)
				multi_history[k] = multi_history[k - 1];
			multi_history[0] = issued_multi;
		end
	end

	initial
	begin
		thread_pending = '0;
		thread_request = '0;
		reset = 1'b1;
		load_cases();
		timeout_limit = case_count * (multiply_stages + 8) + 100;
		repeat (8)
			@(posedge clk);
		#1;
		reset = 1'b0;
		fork
			run_thread(0);
			run_thread(1);
			run_thread(2);
			run_thread(3);
		join
		repeat (multi_latency + 2)
			@(posedge clk);
		if (results_seen == case_count && outstanding == '0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
			fail_run("the run ended with fewer results than cases");
	end

endmodule

/* tb/execute_cases.txt */
// Columns: thread, instruction word, operand a, operand b, expected result (all hex)
// Instruction bit 31 selects immediate format, bits 30:27 hold the opcode
0 00000000 00000005 00000007 0000000c
1 08000000 00000003 00000005 fffffffe
2 10000000 f0f0ff00 0ff0f0f0 00f0f000
3 18000000 12340000 00005678 12345678
0 20000000 ffff0000 0f0f0f0f f0f00f0f
1 00000000 ffffffff 00000002 00000001
2 28000000 00010000 00010000 00000000
3 30000000 00010000 00010000 00000001
0 28000000 00001234 00000010 00012340
1 30000000 ffffffff ffffffff fffffffe
2 28000000 ffffffff ffffffff 00000001
3 8000ffff 00000010 deadbeef 0000000f
0 88000010 00000100 12345678 000000f0
1 90008000 12345678 00000000 12340000
2 98007fff a5a50000 ffffffff a5a57fff
3 a000ffff 0000ffff 00000000 ffff0000
0 a8000003 00000007 99999999 00000015
1 b000fffe 00000002 00000000 00000001
2 38000000 11111111 22222222 00000000
3 28000000 0000ffff 0000ffff fffe0001
0 00000000 80000000 80000000 00000000
1 08000000 00000000 00000001 ffffffff
2 30000000 80000000 00000004 00000002
3 08000000 00001000 00000001 00000fff
0 30000000 12345678 00000100 00000012
1 18000000 0000f000 00000f00 0000ff00
2 20000000 aaaaaaaa 55555555 ffffffff
3 10000000 ffffffff 13579bdf 13579bdf

/* compile.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/latency_decoder.sv
design/execute_hazard_detect.sv
design/thread_issue.sv
design/single_cycle_alu.sv
design/multi_cycle_multiplier.sv
design/writeback_merge.sv
design/execute_pipeline.sv
tb/execute_pipeline_tb.sv

/* Makefile */
VERILATOR = verilator
TOP = execute_pipeline_tb
FILELIST = compile.f
BUILD_DIR = obj_dir
COMMON_FLAGS = --timing --timescale 1ns/100ps --top-module $(TOP)
LINT_FLAGS = --lint-only $(COMMON_FLAGS)
SIM_FLAGS = --binary --assert -j 0 $(COMMON_FLAGS) -Mdir $(BUILD_DIR) -o $(TOP)
PASS_MESSAGE = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)
